//--- logic/fme_config.svh
`ifndef FME_CONFIG_SVH
`define FME_CONFIG_SVH

// integer sample width
`define FME_PIXEL_BITS 8

// integer pixels per reference row
`define FME_ROW_PIXELS 16

// luma filter length
`define FME_TAPS 8

// fractional samples per row is row pixels minus taps plus one
`define FME_FRAC_PIXELS 9

// reference rows per block
`define FME_BLOCK_ROWS 8

// rounding offset and normalising shift for taps summing to 64
`define FME_ROUND 32
`define FME_SHIFT 6

`endif

//--- logic/fme_pkg.sv
`default_nettype none

`include "fme_config.svh"

package fme_pkg;

	// one integer or clipped fractional sample
	typedef logic [`FME_PIXEL_BITS-1:0] pixel_t;

	// a whole integer row with pixel 0 in the low bits
	typedef pixel_t [`FME_ROW_PIXELS-1:0] pixel_row_t;

	// one filter's clipped output row
	typedef pixel_t [`FME_FRAC_PIXELS-1:0] frac_row_t;

	// tap sum, wide enough for 88 * 255 plus rounding
	typedef logic signed [15:0] filter_sum_t;

	// counts rows inside one block
	typedef logic [$clog2(`FME_BLOCK_ROWS)-1:0] row_index_t;

	// phases of one block
	typedef enum logic [1:0] {
		idle,
		load,
		filter,
		done
	} fme_state_t;

endpackage

`default_nettype wire

//--- logic/fme_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "fme_config.svh"

module fme_control (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic row_valid,
	output logic write_row,
	output logic read_row,
	output logic filter_en,
	output logic load_done,
	output logic filter_done
);
	import fme_pkg::*;

	fme_state_t state;
	fme_state_t state_next;
	row_index_t row_count; // accepted rows in load, reads in filter
	logic start_ok;
	logic last_row;

	assign start_ok = start && ((state == idle) || (state == done)); // ignored mid block
	assign write_row = (state == load) && row_valid;
	assign read_row = (state == filter);
	assign filter_en = read_row; // filter bank samples the same cycle
	assign last_row = (row_count == row_index_t'(`FME_BLOCK_ROWS - 1));

	always_comb begin
		state_next = state;
		case (state)
			idle, done: begin
				if (start_ok) begin
					state_next = load;
				end
			end
			load: begin
				if (write_row && last_row) begin
					state_next = filter; // eighth row stored on this edge
				end
			end
			filter: begin
				if (last_row) begin
					state_next = done;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			row_count <= '0;
		end else if (start_ok) begin
			row_count <= '0;
		end else if (write_row || read_row) begin
			if (last_row) begin
				row_count <= '0; // reused by the next phase
			end else begin
				row_count <= row_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			load_done <= 1'b0;
			filter_done <= 1'b0;
		end else if (start_ok) begin
			load_done <= 1'b0;
			filter_done <= 1'b0;
		end else begin
			if (write_row && last_row) begin
				load_done <= 1'b1;
			end
			if (read_row && last_row) begin
				filter_done <= 1'b1; // lines up with the last out_valid
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/row_window_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "fme_config.svh"

module row_window_buffer (
	input  logic               clock,
	input  logic               reset,
	input  logic               write_row,
	input  logic               read_row,
	input  fme_pkg::pixel_row_t row_in,
	output fme_pkg::pixel_row_t row_out
);
	import fme_pkg::*;

	localparam row_index_t last_index = row_index_t'(`FME_BLOCK_ROWS - 1);

	pixel_row_t rows [`FME_BLOCK_ROWS];
	row_index_t wr_ptr;
	row_index_t rd_ptr;

	// row storage, written in load order
	always_ff @(posedge clock) begin
		if (write_row) begin
			rows[wr_ptr] <= row_in;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (write_row) begin
			if (wr_ptr == last_index) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// wrap after the eighth read leaves the window ready for the next block
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (read_row) begin
			if (rd_ptr == last_index) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign row_out = rows[rd_ptr]; // oldest unread row

endmodule

`default_nettype wire

//--- logic/frac_filter_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "fme_config.svh"

module frac_filter_bank (
	input  logic               clock,
	input  logic               reset,
	input  logic               filter_en,
	input  fme_pkg::pixel_row_t row_in,
	output fme_pkg::frac_row_t  frac_a,
	output fme_pkg::frac_row_t  frac_b,
	output fme_pkg::frac_row_t  frac_c,
	output logic               out_valid
);
	import fme_pkg::*;

	typedef filter_sum_t coef_set_t [`FME_TAPS];

	// HEVC luma interpolation taps
	localparam coef_set_t coef_a = '{-1, 4, -10, 58, 17, -5, 1, 0}; // quarter pel
	localparam coef_set_t coef_b = '{-1, 4, -11, 40, 40, -11, 4, -1}; // half pel
	localparam coef_set_t coef_c = '{0, 1, -5, 17, 58, -10, 4, -1}; // three quarter pel

	localparam filter_sum_t pixel_max = filter_sum_t'((1 << `FME_PIXEL_BITS) - 1);

	frac_row_t next_a;
	frac_row_t next_b;
	frac_row_t next_c;

	// rounded and normalised tap sum at one position
	function automatic filter_sum_t tap_sum(input pixel_row_t row, input int pos,
		input coef_set_t coef);
		filter_sum_t sum;
		sum = filter_sum_t'(`FME_ROUND);
		for (int t = 0; t < `FME_TAPS; t++) begin
			sum = sum + coef[t] * filter_sum_t'(row[pos + t]); // pixel zero extended
		end
		return sum >>> `FME_SHIFT;
	endfunction

	function automatic pixel_t clip_pixel(input filter_sum_t value);
		pixel_t result;
		if (value < 0) begin
			result = '0;
		end else if (value > pixel_max) begin
			result = '1;
		end else begin
			result = pixel_t'(value);
		end
		return result;
	endfunction

	// nine positions per filter
	always_comb begin
		for (int k = 0; k < `FME_FRAC_PIXELS; k++) begin
			next_a[k] = clip_pixel(tap_sum(row_in, k, coef_a));
			next_b[k] = clip_pixel(tap_sum(row_in, k, coef_b));
			next_c[k] = clip_pixel(tap_sum(row_in, k, coef_c));
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			frac_a <= '0;
			frac_b <= '0;
			frac_c <= '0;
		end else if (filter_en) begin
			frac_a <= next_a;
			frac_b <= next_b;
			frac_c <= next_c;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= filter_en; // one cycle behind the read
		end
	end

endmodule

`default_nettype wire

//--- logic/fme_horizontal_core.sv
`timescale 1ns/100ps
`default_nettype none

module fme_horizontal_core (
	input  logic               clock,
	input  logic               reset,
	input  logic               start,
	input  logic               row_valid,
	input  fme_pkg::pixel_row_t row_in,
	output fme_pkg::frac_row_t  frac_a,
	output fme_pkg::frac_row_t  frac_b,
	output fme_pkg::frac_row_t  frac_c,
	output logic               out_valid,
	output logic               load_done,
	output logic               filter_done
);
	import fme_pkg::*;

	logic write_row;
	logic read_row;
	logic filter_en;
	pixel_row_t window_row; // combinational read of the oldest row

	fme_control u_control (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.row_valid   (row_valid),
		.write_row   (write_row),
		.read_row    (read_row),
		.filter_en   (filter_en),
		.load_done   (load_done),
		.filter_done (filter_done)
	);

	row_window_buffer u_window (
		.clock     (clock),
		.reset     (reset),
		.write_row (write_row),
		.read_row  (read_row),
		.row_in    (row_in),
		.row_out   (window_row)
	);

	frac_filter_bank u_filters (
		.clock     (clock),
		.reset     (reset),
		.filter_en (filter_en),
		.row_in    (window_row),
		.frac_a    (frac_a),
		.frac_b    (frac_b),
		.frac_c    (frac_c),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

//--- verif/fme_props.sv
`timescale 1ns/100ps
`default_nettype none

module fme_props (
	input logic                clock,
	input logic                reset,
	input logic                row_valid,
	input logic                out_valid,
	input logic                load_done,
	input logic                filter_done,
	input fme_pkg::fme_state_t state
);
	import fme_pkg::*;

	int unsigned fail_count = 0; // failed properties so far

	assert property (@(posedge clock) disable iff (reset) (state == load) |-> !out_valid)
	else begin
		fail_count++;
		$error("out_valid high while the block is still loading");
	end

	// only the edge that stores the eighth row may raise it
	assert property (@(posedge clock) disable iff (reset)
		$rose(load_done) |-> $past((state == load) && row_valid))
	else begin
		fail_count++;
		$error("load_done rose without an accepted row");
	end

	assert property (@(posedge clock) disable iff (reset)
		$rose(out_valid) |-> out_valid [*8] ##1 !out_valid)
	else begin
		fail_count++;
		$error("out_valid burst is not eight consecutive cycles");
	end

	assert property (@(posedge clock) disable iff (reset)
		$rose(out_valid) |-> ##7 ($rose(filter_done) && out_valid))
	else begin
		fail_count++;
		$error("filter_done did not rise with the last out_valid");
	end

endmodule

bind fme_horizontal_core fme_props u_props (
	.clock       (clock),
	.reset       (reset),
	.row_valid   (row_valid),
	.out_valid   (out_valid),
	.load_done   (load_done),
	.filter_done (filter_done),
	.state       (u_control.state)
);

`default_nettype wire

//--- verif/fme_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fme_config.svh"

module fme_tb;
	import fme_pkg::*;

	localparam int max_wait = 100;

	logic clock = 1'b0;
	logic reset;
	logic start;
	logic row_valid;
	pixel_row_t row_in;
	frac_row_t frac_a;
	frac_row_t frac_b;
	frac_row_t frac_c;
	logic out_valid;
	logic load_done;
	logic filter_done;

	// model copy of the luma taps
	int coef_a [`FME_TAPS] = '{-1, 4, -10, 58, 17, -5, 1, 0};
	int coef_b [`FME_TAPS] = '{-1, 4, -11, 40, 40, -11, 4, -1};
	int coef_c [`FME_TAPS] = '{0, 1, -5, 17, 58, -10, 4, -1};

	frac_row_t exp_a_q [$];
	frac_row_t exp_b_q [$];
	frac_row_t exp_c_q [$];
	pixel_row_t block_rows [`FME_BLOCK_ROWS];
	logic [31:0] rng = 32'h8488;
	int cycle_count = 0;
	int strobe_cycle = 0; // cycle of the latest accepted row
	int first_valid_cycle = 0;
	int out_count = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;

	fme_horizontal_core dut (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.row_valid   (row_valid),
		.row_in      (row_in),
		.frac_a      (frac_a),
		.frac_b      (frac_b),
		.frac_c      (frac_c),
		.out_valid   (out_valid),
		.load_done   (load_done),
		.filter_done (filter_done)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// round, arithmetic shift, clip to the pixel range
	function automatic frac_row_t filter_row(input pixel_row_t row, input int coef [`FME_TAPS]);
		frac_row_t result;
		int sum;
		for (int k = 0; k < `FME_FRAC_PIXELS; k++) begin
			sum = `FME_ROUND;
			for (int t = 0; t < `FME_TAPS; t++) begin
				sum += coef[t] * int'(row[k + t]);
			end
			sum = sum >>> `FME_SHIFT;
			result[k] = (sum < 0) ? 8'd0 : ((sum > 255) ? 8'd255 : pixel_t'(sum));
		end
		return result;
	endfunction

	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic fill_flat(input pixel_t v);
		for (int r = 0; r < `FME_BLOCK_ROWS; r++) begin
			block_rows[r] = {`FME_ROW_PIXELS{v}};
		end
	endtask

	task automatic fill_random();
		for (int r = 0; r < `FME_BLOCK_ROWS; r++) begin
			for (int p = 0; p < `FME_ROW_PIXELS; p++) begin
				rng = xorshift(rng);
				block_rows[r][p] = rng[7:0];
			end
		end
	endtask

	// pairs of 0 and 255 drive tap sums past both clip limits
	task automatic fill_alternating();
		for (int r = 0; r < `FME_BLOCK_ROWS; r++) begin
			for (int p = 0; p < `FME_ROW_PIXELS; p++) begin
				block_rows[r][p] = (((p + r) / 2) % 2 == 1) ? 8'd255 : 8'd0;
			end
		end
	endtask

	task automatic load_block(input bit gaps, input bit stray_start);
		int idle_cycles;
		for (int i = 0; i < `FME_BLOCK_ROWS; i++) begin
			idle_cycles = 0;
			if (gaps) begin
				rng = xorshift(rng);
				idle_cycles = rng % 3;
			end
			repeat (idle_cycles) begin
				row_valid = 1'b0;
				tick();
			end
			row_in = block_rows[i];
			row_valid = 1'b1;
			start = stray_start && (i == 4); // must be ignored mid block
			exp_a_q.push_back(filter_row(block_rows[i], coef_a));
			exp_b_q.push_back(filter_row(block_rows[i], coef_b));
			exp_c_q.push_back(filter_row(block_rows[i], coef_c));
			strobe_cycle = cycle_count;
			tick();
		end
		row_valid = 1'b0;
		start = 1'b0;
	endtask

	task automatic wait_filter_done();
		int waited;
		waited = 0;
		while (!filter_done && waited < max_wait) begin
			@(negedge clock);
			waited++;
		end
		if (!filter_done) begin
			errors++;
			$display("timeout: filter_done did not rise within %0d cycles", max_wait);
		end
		tick();
	endtask

	// start, eight rows, optional strobes during filter, then wait for the burst
	task automatic run_block(input bit gaps, input bit stray_start, input bit filter_strobes);
		start = 1'b1;
		tick();
		start = 1'b0;
		assert (!load_done && !filter_done) else begin
			errors++;
			$display("mismatch at %0t ns: done levels not cleared by start", $time);
		end
		load_block(gaps, stray_start);
		assert (load_done) else begin
			errors++;
			$display("mismatch at %0t ns: load_done low after the eighth row", $time);
		end
		if (filter_strobes) begin
			repeat (3) begin
				rng = xorshift(rng);
				row_in = {`FME_ROW_PIXELS{rng[7:0]}};
				row_valid = 1'b1;
				tick();
			end
			row_valid = 1'b0;
		end
		wait_filter_done();
	endtask

	task automatic end_test(input string name);
		assert (exp_a_q.size() == 0) else begin
			errors++;
			$display("%0d expected rows never came out", exp_a_q.size());
		end
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
		test_errors = errors;
	endtask

	always @(negedge clock) begin
		if (!reset && out_valid) begin
			if (exp_a_q.size() == 0) begin
				errors++;
				$display("out_valid at %0t ns with no row left to compare", $time);
			end else begin
				if (out_count == 0) begin
					first_valid_cycle = cycle_count;
					assert (cycle_count - strobe_cycle == 2) else begin
						errors++;
						$display("mismatch at %0t ns: first out_valid after %0d cycles, expected 2",
							$time, cycle_count - strobe_cycle);
					end
				end
				assert (frac_a == exp_a_q[0]) else begin
					errors++;
					$display("mismatch at %0t ns: frac_a row %0d is %h, expected %h",
						$time, out_count, frac_a, exp_a_q[0]);
				end
				assert (frac_b == exp_b_q[0]) else begin
					errors++;
					$display("mismatch at %0t ns: frac_b row %0d is %h, expected %h",
						$time, out_count, frac_b, exp_b_q[0]);
				end
				assert (frac_c == exp_c_q[0]) else begin
					errors++;
					$display("mismatch at %0t ns: frac_c row %0d is %h, expected %h",
						$time, out_count, frac_c, exp_c_q[0]);
				end
				exp_a_q.delete(0);
				exp_b_q.delete(0);
				exp_c_q.delete(0);
				out_count++;
				if (out_count == `FME_BLOCK_ROWS) begin
					out_count = 0;
					assert (filter_done && (cycle_count - first_valid_cycle == 7)) else begin
						errors++;
						$display("mismatch at %0t ns: last row without filter_done or late", $time);
					end
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		row_valid = 1'b0;
		row_in = '0;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (4) begin
			@(negedge clock);
			assert (!out_valid && !load_done && !filter_done && frac_a == '0 && frac_b == '0
				&& frac_c == '0) else begin
				errors++;
				$display("mismatch at %0t ns: outputs not idle after reset", $time);
			end
		end
		tick();
		end_test("reset state");
		fill_flat(8'd137);
		run_block(1'b0, 1'b0, 1'b0);
		end_test("flat block");
		fill_random();
		run_block(1'b0, 1'b0, 1'b0);
		end_test("random block");
		fill_alternating();
		run_block(1'b0, 1'b0, 1'b0);
		end_test("clipping block");
		fill_random();
		run_block(1'b1, 1'b1, 1'b1);
		end_test("gaps and stray strobes");
		fill_random(); // starts straight from done
		run_block(1'b0, 1'b0, 1'b0);
		end_test("back to back block");
		errors = errors + dut.u_props.fail_count;
		$display("tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/fme_pkg.sv
logic/fme_control.sv
logic/row_window_buffer.sv
logic/frac_filter_bank.sv
logic/fme_horizontal_core.sv
verif/fme_props.sv
verif/fme_tb.sv
